/* src/dg_pkg.sv */
`default_nettype none

package dg_pkg;

    // lattice size in rows, columns and measurement rounds
    localparam int GRID_WIDTH_X = 4;
    localparam int GRID_WIDTH_Z = 1;
    localparam int GRID_WIDTH_U = 3;

    // address fields, round in the top bits
    localparam int X_BIT_WIDTH   = $clog2(GRID_WIDTH_X);
    localparam int Z_BIT_WIDTH   = $clog2(GRID_WIDTH_Z);
    localparam int U_BIT_WIDTH   = $clog2(GRID_WIDTH_U);
    localparam int ADDRESS_WIDTH = X_BIT_WIDTH + Z_BIT_WIDTH + U_BIT_WIDTH;

    localparam int PU_COUNT_PER_ROUND = GRID_WIDTH_X * GRID_WIDTH_Z;
    localparam int PU_COUNT           = PU_COUNT_PER_ROUND * GRID_WIDTH_U;

    // growth counter sized for the heaviest link
    localparam int MAX_WEIGHT     = 2;
    localparam int LINK_BIT_WIDTH = $clog2(MAX_WEIGHT + 1);
    // every link carries the same weight
    localparam logic [LINK_BIT_WIDTH-1:0] LINK_WEIGHT = 2;

    // port order on each unit
    localparam int NEIGHBOR_COUNT = 6;
    localparam int NBR_NORTH      = 0;
    localparam int NBR_SOUTH      = 1;
    localparam int NBR_WEST       = 2;
    localparam int NBR_EAST       = 3;
    localparam int NBR_DOWN       = 4;
    localparam int NBR_UP         = 5;

    localparam int STAGE_WIDTH = 2;

    // global stage, held as a level by the controller
    typedef enum logic [STAGE_WIDTH-1:0] {
        STAGE_IDLE                = 2'd0,
        STAGE_MEASUREMENT_LOADING = 2'd1,
        STAGE_GROW                = 2'd2,
        STAGE_MERGE               = 2'd3
    } stage_e;

    typedef logic [ADDRESS_WIDTH-1:0] address_t;

    // unit side of a link
    typedef struct packed {
        logic     increase;
        address_t root;
    } pu_to_link_t;

    // link side, peer_root is the root of the far end
    typedef struct packed {
        logic     fully_grown;
        address_t peer_root;
    } link_to_pu_t;

endpackage

`default_nettype wire

/* src/processing_unit.sv */
`timescale 1ns/1ns
`default_nettype none

module processing_unit #(
    parameter dg_pkg::address_t ADDRESS = '0
) (
    input  wire                                                    clk,
    input  wire                                                    rst_i,
    input  wire dg_pkg::stage_e                                    global_stage_i,
    input  wire                                                    measurement_i,
    output logic                                                   measurement_o,
    input  wire dg_pkg::link_to_pu_t [dg_pkg::NEIGHBOR_COUNT-1:0] neighbor_i,
    output dg_pkg::pu_to_link_t                                    link_o,
    output dg_pkg::address_t                                       root_o,
    output logic                                                   busy_o
);

    import dg_pkg::*;

    // held syndrome bit for this vertex
    logic     meas_q;
    // current cluster root
    address_t root_q;
    // root moved on the last merge cycle
    logic     busy_q;
    // smallest root seen across grown ports
    address_t min_root;

    // lowest address among own root and grown neighbors
    always_comb begin
        min_root = root_q;
        for (int n = 0; n < NEIGHBOR_COUNT; n++) begin
            // absent ports are tied low so they never qualify
            if (neighbor_i[n].fully_grown && (neighbor_i[n].peer_root < min_root)) begin
                min_root = neighbor_i[n].peer_root;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            meas_q <= 1'b0;
            root_q <= ADDRESS;
            busy_q <= 1'b0;
        end else begin
            case (global_stage_i)
                STAGE_MEASUREMENT_LOADING: begin
                    // one systolic shift per cycle
                    meas_q <= measurement_i;
                    // fresh round, every unit is its own cluster again
                    root_q <= ADDRESS;
                    busy_q <= 1'b0;
                end
                STAGE_MERGE: begin
                    root_q <= min_root;
                    // busy only while the root keeps moving
                    busy_q <= (min_root != root_q);
                end
                default: begin
                    // idle and grow hold the root
                    busy_q <= 1'b0;
                end
            endcase
        end
    end

    // old value goes one round down the chain
    assign measurement_o = meas_q;

    // defects drive growth on every attached link
    assign link_o.increase = meas_q;
    assign link_o.root     = root_q;

    assign root_o = root_q;
    assign busy_o = busy_q;

    // roots only ever move toward lower addresses, whatever the neighbors send
    a_root_not_above_own : assert property (
        @(posedge clk) disable iff (rst_i)
        root_q <= ADDRESS
    );

endmodule

`default_nettype wire

/* src/neighbor_link.sv */
`timescale 1ns/1ns
`default_nettype none

module neighbor_link (
    input  wire                      clk,
    input  wire                      rst_i,
    input  wire dg_pkg::stage_e      global_stage_i,
    input  wire dg_pkg::pu_to_link_t a_i,
    input  wire dg_pkg::pu_to_link_t b_i,
    output dg_pkg::link_to_pu_t      a_o,
    output dg_pkg::link_to_pu_t      b_o
);

    import dg_pkg::*;

    // accumulated growth from both ends
    logic [LINK_BIT_WIDTH-1:0] growth_q;
    logic [LINK_BIT_WIDTH-1:0] growth_d;
    // one spare bit so the sum cannot wrap
    logic [LINK_BIT_WIDTH:0]   growth_sum;
    logic                      fully_grown_q;

    // both ends may push in the same cycle
    always_comb begin
        growth_sum = {1'b0, growth_q}
                   + {{LINK_BIT_WIDTH{1'b0}}, a_i.increase}
                   + {{LINK_BIT_WIDTH{1'b0}}, b_i.increase};
        if (growth_sum >= {1'b0, LINK_WEIGHT}) begin
            growth_d = LINK_WEIGHT;
        end else begin
            growth_d = growth_sum[LINK_BIT_WIDTH-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            growth_q      <= '0;
            fully_grown_q <= 1'b0;
        end else begin
            case (global_stage_i)
                STAGE_MEASUREMENT_LOADING: begin
                    growth_q      <= '0;
                    fully_grown_q <= 1'b0;
                end
                STAGE_GROW: begin
                    growth_q <= growth_d;
                    // ready for merge on the very next cycle
                    fully_grown_q <= (growth_d == LINK_WEIGHT);
                end
                default: begin
                    // idle and merge keep the edge as it is
                    growth_q      <= growth_q;
                    fully_grown_q <= fully_grown_q;
                end
            endcase
        end
    end

    // each end sees the other end's root
    assign a_o.fully_grown = fully_grown_q;
    assign a_o.peer_root   = b_i.root;
    assign b_o.fully_grown = fully_grown_q;
    assign b_o.peer_root   = a_i.root;

    // saturation holds across any run of grow cycles
    a_growth_capped : assert property (
        @(posedge clk) disable iff (rst_i)
        growth_q <= LINK_WEIGHT
    );

endmodule

`default_nettype wire

/* src/decoding_graph.sv */
`timescale 1ns/1ns
`default_nettype none

module decoding_graph (
    input  wire                                          clk,
    input  wire                                          rst_i,
    input  wire dg_pkg::stage_e                          global_stage_i,
    input  wire [dg_pkg::PU_COUNT_PER_ROUND-1:0]         measurements_i,
    output wire dg_pkg::address_t [dg_pkg::PU_COUNT-1:0] roots_o,
    output wire [dg_pkg::PU_COUNT-1:0]                   busy_o
);

    import dg_pkg::*;

    // flat index, round major then row then column
    function automatic int pu_index(input int row, input int col, input int round);
        return round * PU_COUNT_PER_ROUND + row * GRID_WIDTH_Z + col;
    endfunction

    function automatic address_t pu_address(input int row, input int col, input int round);
        return address_t'((round << (X_BIT_WIDTH + Z_BIT_WIDTH)) + (row << Z_BIT_WIDTH) + col);
    endfunction

    // south port links to the next row, staggered on even rows
    function automatic bit has_south(input int row, input int col);
        if (row + 1 >= GRID_WIDTH_X) begin
            return 1'b0;
        end
        return ((row + 1) % 2 == 1) || (col < GRID_WIDTH_Z - 1);
    endfunction

    function automatic int south_col(input int row, input int col);
        return ((row + 1) % 2 == 1) ? col : col + 1;
    endfunction

    // mirror of has_south seen from the lower row
    function automatic bit has_north(input int row, input int col);
        return (row > 0) && ((row % 2 == 1) || (col >= 1));
    endfunction

    // east port links to the row above
    function automatic bit has_east(input int row, input int col);
        return (row > 0) && ((row % 2 == 0) || (col < GRID_WIDTH_Z - 1));
    endfunction

    function automatic int east_col(input int row, input int col);
        return (row % 2 == 0) ? col : col + 1;
    endfunction

    // mirror of has_east seen from the row above
    function automatic bit has_west(input int row, input int col);
        return (row + 1 < GRID_WIDTH_X) && (((row + 1) % 2 == 0) || (col >= 1));
    endfunction

    // per unit link bundle and returned port data
    wire pu_to_link_t                      pu_link [PU_COUNT];
    wire link_to_pu_t [NEIGHBOR_COUNT-1:0] pu_nbr  [PU_COUNT];
    // held measurement of every unit, feeds the round below
    wire                                   pu_meas [PU_COUNT];

    for (genvar k = 0; k < GRID_WIDTH_U; k++) begin : g_round
        for (genvar r = 0; r < GRID_WIDTH_X; r++) begin : g_row
            for (genvar c = 0; c < GRID_WIDTH_Z; c++) begin : g_col
                wire meas_in;

                // newest round reads the inputs, older rounds read the round above
                if (k == GRID_WIDTH_U - 1) begin : g_meas_top
                    assign meas_in = measurements_i[r * GRID_WIDTH_Z + c];
                end else begin : g_meas_chain
                    assign meas_in = pu_meas[pu_index(r, c, k + 1)];
                end

                processing_unit #(
                    .ADDRESS(pu_address(r, c, k))
                ) u_pu (
                    .clk            (clk),
                    .rst_i          (rst_i),
                    .global_stage_i (global_stage_i),
                    .measurement_i  (meas_in),
                    .measurement_o  (pu_meas[pu_index(r, c, k)]),
                    .neighbor_i     (pu_nbr[pu_index(r, c, k)]),
                    .link_o         (pu_link[pu_index(r, c, k)]),
                    .root_o         (roots_o[pu_index(r, c, k)]),
                    .busy_o         (busy_o[pu_index(r, c, k)])
                );

                // the upper end of each planar edge owns the link
                if (has_south(r, c)) begin : g_ns
                    neighbor_link u_link (
                        .clk            (clk),
                        .rst_i          (rst_i),
                        .global_stage_i (global_stage_i),
                        .a_i            (pu_link[pu_index(r, c, k)]),
                        .b_i            (pu_link[pu_index(r + 1, south_col(r, c), k)]),
                        .a_o            (pu_nbr[pu_index(r, c, k)][NBR_SOUTH]),
                        .b_o            (pu_nbr[pu_index(r + 1, south_col(r, c), k)][NBR_NORTH])
                    );
                end else begin : g_no_south
                    assign pu_nbr[pu_index(r, c, k)][NBR_SOUTH] = '0;
                end

                if (!has_north(r, c)) begin : g_no_north
                    assign pu_nbr[pu_index(r, c, k)][NBR_NORTH] = '0;
                end

                // east of this row meets west of the row above
                if (has_east(r, c)) begin : g_ew
                    neighbor_link u_link (
                        .clk            (clk),
                        .rst_i          (rst_i),
                        .global_stage_i (global_stage_i),
                        .a_i            (pu_link[pu_index(r, c, k)]),
                        .b_i            (pu_link[pu_index(r - 1, east_col(r, c), k)]),
                        .a_o            (pu_nbr[pu_index(r, c, k)][NBR_EAST]),
                        .b_o            (pu_nbr[pu_index(r - 1, east_col(r, c), k)][NBR_WEST])
                    );
                end else begin : g_no_east
                    assign pu_nbr[pu_index(r, c, k)][NBR_EAST] = '0;
                end

                if (!has_west(r, c)) begin : g_no_west
                    assign pu_nbr[pu_index(r, c, k)][NBR_WEST] = '0;
                end

                // vertical edge to the same site one round later
                if (k < GRID_WIDTH_U - 1) begin : g_ud
                    neighbor_link u_link (
                        .clk            (clk),
                        .rst_i          (rst_i),
                        .global_stage_i (global_stage_i),
                        .a_i            (pu_link[pu_index(r, c, k)]),
                        .b_i            (pu_link[pu_index(r, c, k + 1)]),
                        .a_o            (pu_nbr[pu_index(r, c, k)][NBR_UP]),
                        .b_o            (pu_nbr[pu_index(r, c, k + 1)][NBR_DOWN])
                    );
                end else begin : g_no_up
                    assign pu_nbr[pu_index(r, c, k)][NBR_UP] = '0;
                end

                // oldest round has nothing below
                if (k == 0) begin : g_no_down
                    assign pu_nbr[pu_index(r, c, k)][NBR_DOWN] = '0;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* dv/tb_decoding_graph.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_decoding_graph;

    import dg_pkg::*;

    localparam int CLK_PERIOD      = 4;
    localparam int RESET_CYCLES    = 3;
    localparam int DIR_COUNT       = 7;
    localparam int RAND_COUNT      = 8;
    localparam int ENTRY_COUNT     = DIR_COUNT + RAND_COUNT;
    // loading, grow, worst merge and some slack per entry
    localparam int WATCHDOG_CYCLES = ENTRY_COUNT * (GRID_WIDTH_U + 2 + PU_COUNT + 4) + 10;
    localparam int unsigned RAND_SEED = 32'ha089_b01b;

    // one pattern per round with round 0 in the low bits
    typedef logic [GRID_WIDTH_U-1:0][PU_COUNT_PER_ROUND-1:0] pattern_t;
    // one nibble per unit with unit 0 in the low bits
    typedef address_t [PU_COUNT-1:0] roots_t;

    typedef struct packed {
        pattern_t   pattern;
        logic [1:0] grow;
        roots_t     roots;
    } entry_t;

    logic                          clk;
    logic                          rst_i;
    stage_e                        global_stage_i;
    logic [PU_COUNT_PER_ROUND-1:0] measurements_i;
    roots_t                        roots_o;
    logic [PU_COUNT-1:0]           busy_o;

    entry_t      entries [$];
    int          error_count;
    int          check_count;

    decoding_graph u_decoding_graph (
        .clk            (clk),
        .rst_i          (rst_i),
        .global_stage_i (global_stage_i),
        .measurements_i (measurements_i),
        .roots_o        (roots_o),
        .busy_o         (busy_o)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("CHECK FAILED at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
        end
    endtask

    // every unit in its own cluster
    function automatic roots_t own_roots();
        roots_t res;
        for (int k = 0; k < GRID_WIDTH_U; k++) begin
            for (int r = 0; r < GRID_WIDTH_X; r++) begin
                for (int c = 0; c < GRID_WIDTH_Z; c++) begin
                    res[k * PU_COUNT_PER_ROUND + r * GRID_WIDTH_Z + c] =
                        address_t'((k << (X_BIT_WIDTH + Z_BIT_WIDTH)) + (r << Z_BIT_WIDTH) + c);
                end
            end
        end
        return res;
    endfunction

    // each grow cycle adds one per defect end up to the ceiling
    function automatic bit edge_full(input bit da, input bit db, input int grow);
        int growth;
        growth = grow * (int'(da) + int'(db));
        if (growth > MAX_WEIGHT) begin
            growth = MAX_WEIGHT;
        end
        return growth >= int'(LINK_WEIGHT);
    endfunction

    // connected components over grown edges of the single column lattice
    function automatic roots_t model_roots(input pattern_t pat, input int grow);
        roots_t   res;
        bit       da;
        bit       db;
        int       j;
        bit       valid;
        address_t m;
        res = own_roots();
        // enough passes for the longest path through the lattice
        for (int pass = 0; pass < PU_COUNT; pass++) begin
            for (int i = 0; i < PU_COUNT; i++) begin
                // side 0 is the next row and side 1 the next round
                for (int side = 0; side < 2; side++) begin
                    j     = (side == 0) ? i + 1 : i + PU_COUNT_PER_ROUND;
                    valid = (side == 0) ? ((i % PU_COUNT_PER_ROUND) < PU_COUNT_PER_ROUND - 1)
                                        : (j < PU_COUNT);
                    if (valid) begin
                        da = pat[i / PU_COUNT_PER_ROUND][i % PU_COUNT_PER_ROUND];
                        db = pat[j / PU_COUNT_PER_ROUND][j % PU_COUNT_PER_ROUND];
                        if (edge_full(da, db, grow)) begin
                            m      = (res[i] < res[j]) ? res[i] : res[j];
                            res[i] = m;
                            res[j] = m;
                        end
                    end
                end
            end
        end
        return res;
    endfunction

    task automatic check_outputs(input roots_t exp);
        for (int i = 0; i < PU_COUNT; i++) begin
            check_value($sformatf("roots_o[%0d]", i), 64'(roots_o[i]), 64'(exp[i]));
        end
        check_value("busy_o", 64'(busy_o), 64'd0);
    endtask

    task automatic run_entry(input int idx, input entry_t e);
        int merge_cycles;
        bit settled;
        merge_cycles = 0;
        settled      = 1'b0;
        // first pattern in ends up in round 0
        global_stage_i = STAGE_MEASUREMENT_LOADING;
        for (int k = 0; k < GRID_WIDTH_U; k++) begin
            measurements_i = e.pattern[k];
            @(negedge clk);
        end
        // loading wipes every earlier cluster
        check_outputs(own_roots());
        global_stage_i = STAGE_GROW;
        for (int g = 0; g < int'(e.grow); g++) begin
            @(negedge clk);
        end
        // merge ends on the first cycle with no root moving
        global_stage_i = STAGE_MERGE;
        while (!settled && merge_cycles < PU_COUNT) begin
            @(negedge clk);
            merge_cycles++;
            settled = (busy_o == '0);
        end
        if (!settled) begin
            error_count++;
            $display("entry %0d: merge still busy after %0d cycles", idx, merge_cycles);
        end
        // with no grown cluster busy never rises
        if (e.roots == own_roots()) begin
            check_value("merge_cycles", 64'(merge_cycles), 64'd1);
        end
        // idle must hold the merged roots
        global_stage_i = STAGE_IDLE;
        @(negedge clk);
        check_outputs(e.roots);
    endtask

    initial begin
        entry_t e;
        error_count    = 0;
        check_count    = 0;
        void'($urandom(RAND_SEED));
        clk            = 1'b0;
        rst_i          = 1'b1;
        global_stage_i = STAGE_IDLE;
        measurements_i = '0;

        // patterns listed from round 2 down to round 0
        // vertical pair in rounds 0 and 1 with one grow cycle
        entries.push_back('{pattern: {4'b0000, 4'b0010, 4'b0010}, grow: 2'd1,
                            roots: 48'hBA98_7614_3210});
        // planar pair in the newest round
        entries.push_back('{pattern: {4'b1100, 4'b0000, 4'b0000}, grow: 2'd1,
                            roots: 48'hAA98_7654_3210});
        // lone defect reaches its neighbors only after two cycles
        entries.push_back('{pattern: {4'b0000, 4'b0001, 4'b0000}, grow: 2'd2,
                            roots: 48'hBA90_7600_3210});
        // no growth at all
        entries.push_back('{pattern: {4'b1111, 4'b1111, 4'b1111}, grow: 2'd0,
                            roots: 48'hBA98_7654_3210});
        // chain over rows 0 to 3
        entries.push_back('{pattern: {4'b1111, 4'b0000, 4'b0000}, grow: 2'd1,
                            roots: 48'h8888_7654_3210});
        // whole lattice merged
        entries.push_back('{pattern: {4'b1111, 4'b1111, 4'b1111}, grow: 2'd2,
                            roots: 48'h0000_0000_0000});
        // clean load right after the full merge
        entries.push_back('{pattern: {4'b0000, 4'b0000, 4'b0000}, grow: 2'd2,
                            roots: 48'hBA98_7654_3210});

        for (int n = 0; n < RAND_COUNT; n++) begin
            e.pattern = pattern_t'($urandom());
            e.grow    = 2'($urandom_range(2, 0));
            e.roots   = model_roots(e.pattern, int'(e.grow));
            entries.push_back(e);
        end

        repeat (RESET_CYCLES) @(negedge clk);
        rst_i = 1'b0;
        check_outputs(own_roots());

        for (int i = 0; i < entries.size(); i++) begin
            run_entry(i, entries[i]);
        end

        $display("checks run: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired after %0d cycles, a stage never finished", WATCHDOG_CYCLES);
        $display("Done: errors found");
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
src/dg_pkg.sv
src/processing_unit.sv
src/neighbor_link.sv
src/decoding_graph.sv
dv/tb_decoding_graph.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the decoding graph testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=obj_dir/tb_decoding_graph

verilator --binary --timing --assert \
    -f src.f \
    --top-module tb_decoding_graph \
    -Mdir obj_dir \
    -o tb_decoding_graph
if [ $? -ne 0 ]; then
    echo "run_sim: compile failed"
    exit 1
fi

"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "run_sim: simulation exited with status $status"
    exit 1
fi

if grep -qx "Done: no errors" "$LOG"; then
    echo "run_sim: PASS"
    exit 0
fi
echo "run_sim: FAIL"
exit 1
